//--- mem_subsys.f
rtl/mem_cmd_pkg.sv
rtl/mem_map_pkg.sv
rtl/mem_bank.sv
rtl/bank_return_merge.sv
rtl/mem_port_arbiter.sv
rtl/mem_subsys_top.sv
dv/mem_subsys_chk.sv
dv/mem_subsys_checker.sv
dv/mem_subsys_tb.sv

//--- Bender.yml
package:
  name: mem_subsys

sources:
  - rtl/mem_cmd_pkg.sv
  - rtl/mem_map_pkg.sv
  - rtl/mem_bank.sv
  - rtl/bank_return_merge.sv
  - rtl/mem_port_arbiter.sv
  - rtl/mem_subsys_top.sv
  - target: test
    files:
      - dv/mem_subsys_chk.sv
      - dv/mem_subsys_checker.sv
      - dv/mem_subsys_tb.sv

//--- dv/mem_subsys_tb.sv
module mem_subsys_tb;
    import mem_cmd_pkg::*;
    import mem_map_pkg::*;

    localparam int NUM_BANKS   = DEF_NUM_BANKS;
    localparam int BANK_WORDS  = DEF_BANK_WORDS;
    localparam int MEM_WORDS   = NUM_BANKS * BANK_WORDS;
    localparam int RAND_OPS    = 2000;
    // at most 5 cycles per operation, rounded up to whole thousands
    localparam int CYCLE_LIMIT = ((MEM_WORDS + RAND_OPS) * 5 + 999) / 1000 * 1000;

    logic              clk;
    logic              rst_n;
    logic              inst_start;
    logic              inst_ready;
    logic              inst_valid;
    logic              d_cmd_ready;
    logic              rdata_valid;
    logic              drain_check;
    logic [ADDR_W-1:0] i_addr;
    logic [ADDR_W-1:0] d_addr;
    logic [DATA_W-1:0] inst;
    logic [DATA_W-1:0] rdata;
    logic [DATA_W-1:0] wdata;
    logic [DATA_W-1:0] wmask;
    mem_cmd_e          d_cmd;
    int                error_count;
    int                read_count;
    int                resp_count;
    int                timeout_errors;
    int                cycles;
    integer            seed;

    mem_subsys_top #(
        .NUM_BANKS  (NUM_BANKS),
        .BANK_WORDS (BANK_WORDS)
    ) i_dut (.*);

    mem_subsys_checker #(
        .MEM_WORDS (MEM_WORDS)
    ) i_checker (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // called 2 units after an edge, returns at the same offset
    task automatic wait_idle();
        while (!(inst_ready && d_cmd_ready)) begin
            @(posedge clk);
            #2;
        end
    endtask

    task automatic send_request(
        input logic              fetch,
        input mem_cmd_e          cmd,
        input logic [ADDR_W-1:0] ia,
        input logic [ADDR_W-1:0] da,
        input logic [DATA_W-1:0] wd,
        input logic [DATA_W-1:0] wm
    );
        wait_idle();
        inst_start = fetch;
        i_addr     = ia;
        d_cmd      = cmd;
        d_addr     = da;
        wdata      = wd;
        wmask      = wm;
        @(posedge clk);
        #2;
        inst_start = 1'b0;
        d_cmd      = MEM_CMD_NOP;
    endtask

    task automatic run_random_ops();
        int       kind;
        mem_cmd_e cmd;
        for (int n = 0; n < RAND_OPS; n++) begin
            kind = $unsigned($random(seed)) % 4;
            cmd  = ($random(seed) & 1) ? MEM_CMD_WRITE : MEM_CMD_READ;
            case (kind)
                0: send_request(1'b1, MEM_CMD_NOP, $random(seed), '0, '0, '0);
                1: send_request(1'b0, MEM_CMD_READ, '0, $random(seed), '0, '0);
                2: send_request(1'b0, MEM_CMD_WRITE, '0, $random(seed), $random(seed),
                       $random(seed));
                default: send_request(1'b1, cmd, $random(seed), $random(seed),
                       $random(seed), $random(seed));
            endcase
        end
    endtask

    task automatic report_and_finish();
        int assert_errors;
        assert_errors = i_dut.i_arbiter.i_chk.fail_count;
        $display("closing report: check errors %0d, assertion errors %0d, timeout errors %0d",
            error_count, assert_errors, timeout_errors);
        if (error_count == 0 && assert_errors == 0 && timeout_errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    endtask

    initial begin
        seed           = 8;
        timeout_errors = 0;
        rst_n          = 1'b0;
        inst_start     = 1'b0;
        d_cmd          = MEM_CMD_NOP;
        i_addr         = '0;
        d_addr         = '0;
        wdata          = '0;
        wmask          = '0;
        drain_check    = 1'b0;
        repeat (5) @(posedge clk);
        #2 rst_n = 1'b1;
        // every word written once with a full mask
        for (int w = 0; w < MEM_WORDS; w++) begin
            send_request(1'b0, MEM_CMD_WRITE, '0, ADDR_W'(w * WORD_BYTES), $random(seed), '1);
        end
        run_random_ops();
        wait_idle();
        drain_check = 1'b1;
        @(posedge clk);
        #2 drain_check = 1'b0;
        @(posedge clk);
        report_and_finish();
    end

    initial begin
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
        timeout_errors++;
        report_and_finish();
    end

endmodule

//--- dv/mem_subsys_checker.sv
module mem_subsys_checker #(
    parameter int MEM_WORDS = mem_map_pkg::DEF_NUM_BANKS * mem_map_pkg::DEF_BANK_WORDS
) (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           inst_start,
    input  logic                           inst_ready,
    input  logic [mem_cmd_pkg::ADDR_W-1:0] i_addr,
    input  logic                           inst_valid,
    input  logic [mem_cmd_pkg::DATA_W-1:0] inst,
    input  mem_cmd_pkg::mem_cmd_e          d_cmd,
    input  logic                           d_cmd_ready,
    input  logic [mem_cmd_pkg::ADDR_W-1:0] d_addr,
    input  logic [mem_cmd_pkg::DATA_W-1:0] wdata,
    input  logic [mem_cmd_pkg::DATA_W-1:0] wmask,
    input  logic                           rdata_valid,
    input  logic [mem_cmd_pkg::DATA_W-1:0] rdata,
    input  logic                           drain_check,
    output int                             error_count,
    output int                             read_count,
    output int                             resp_count
);
    import mem_cmd_pkg::*;

    logic [DATA_W-1:0] model [MEM_WORDS];
    logic [DATA_W-1:0] exp_word [$];
    logic              exp_fetch [$];
    logic              reset_seen;

    // byte address to word, wrapped over the whole memory
    function automatic int unsigned word_index(input logic [ADDR_W-1:0] addr);
        return (addr / WORD_BYTES) % MEM_WORDS;
    endfunction

    task automatic value_mismatch(input string msg);
        $display("CHECK FAILED at time %0t: %s", $time, msg);
        error_count++;
    endtask

    task automatic protocol_error(input string msg);
        $display("protocol error at time %0t: %s", $time, msg);
        error_count++;
    endtask

    task automatic take_response(input logic is_fetch, input logic [DATA_W-1:0] word);
        logic [DATA_W-1:0] expected;
        logic              from_fetch;
        if (exp_word.size() == 0) begin
            protocol_error("a response arrived with no read pending");
        end else begin
            resp_count++;
            expected   = exp_word.pop_front();
            from_fetch = exp_fetch.pop_front();
            if (from_fetch != is_fetch) begin
                protocol_error("a response came out of acceptance order");
            end else if (word !== expected) begin
                value_mismatch($sformatf("%s returned %h, expected %h",
                    is_fetch ? "fetch" : "data read", word, expected));
            end
        end
    endtask

    task automatic apply_write();
        int unsigned idx;
        idx = word_index(d_addr);
        // each set mask bit takes the new data bit
        for (int b = 0; b < DATA_W; b++) begin
            if (wmask[b]) begin
                model[idx][b] = wdata[b];
            end
        end
    endtask

    initial begin
        error_count = 0;
        read_count  = 0;
        resp_count  = 0;
        reset_seen  = 1'b0;
    end

    always @(posedge clk) begin
        if (rst_n) begin
            if (!reset_seen && (!inst_ready || !d_cmd_ready || inst_valid || rdata_valid)) begin
                protocol_error("ports were not idle right after reset");
            end
            reset_seen = 1'b1;
            if (exp_word.size() != 0 && (inst_ready || d_cmd_ready)) begin
                protocol_error("a ready was high while a read was still outstanding");
            end
            if (inst_valid) begin
                take_response(1'b1, inst);
            end
            if (rdata_valid) begin
                take_response(1'b0, rdata);
            end
            // fetch queued ahead of a data command from the same cycle
            if (inst_ready && inst_start) begin
                exp_word.push_back(model[word_index(i_addr)]);
                exp_fetch.push_back(1'b1);
                read_count++;
            end
            if (d_cmd_ready && d_cmd == MEM_CMD_READ) begin
                exp_word.push_back(model[word_index(d_addr)]);
                exp_fetch.push_back(1'b0);
                read_count++;
            end
            if (d_cmd_ready && d_cmd == MEM_CMD_WRITE) begin
                apply_write();
            end
            if (drain_check && (exp_word.size() != 0 || resp_count != read_count)) begin
                protocol_error($sformatf("%0d reads accepted but %0d answered",
                    read_count, resp_count));
            end
        end
    end

endmodule

//--- dv/mem_subsys_chk.sv
module mem_subsys_chk #(
    parameter int NUM_BANKS = mem_map_pkg::DEF_NUM_BANKS
) (
    input logic                  clk,
    input logic                  rst_n,
    input logic                  inst_start,
    input mem_cmd_pkg::mem_cmd_e d_cmd,
    input logic                  inst_ready,
    input logic                  d_cmd_ready,
    input logic                  inst_valid,
    input logic                  rdata_valid,
    input logic                  mem_rvalid,
    input logic [NUM_BANKS-1:0]  bank_start,
    input logic                  bank_write
);
    import mem_cmd_pkg::*;

    int fail_count = 0;

    // a written bank sits out the next cycle
    assert property (@(posedge clk) disable iff (!rst_n)
        (bank_write && |bank_start) |=> ((bank_start & $past(bank_start)) == '0))
        else begin
            $error("bank started during its write recovery cycle");
            fail_count++;
        end

    // each bank word goes to exactly one response port
    assert property (@(posedge clk) disable iff (!rst_n)
        mem_rvalid |-> (inst_valid ^ rdata_valid))
        else begin
            $error("bank read data not steered to exactly one port");
            fail_count++;
        end

    // ports stay busy after an accept, unless a lone write went out at once
    assert property (@(posedge clk) disable iff (!rst_n)
        (inst_ready && (inst_start || d_cmd != MEM_CMD_NOP) && !(bank_write && |bank_start))
        |=> (!inst_ready && !d_cmd_ready))
        else begin
            $error("port ready high again right after accepting a request");
            fail_count++;
        end

endmodule

bind mem_port_arbiter mem_subsys_chk #(
    .NUM_BANKS (NUM_BANKS)
) i_chk (
    .clk,
    .rst_n,
    .inst_start,
    .d_cmd,
    .inst_ready,
    .d_cmd_ready,
    .inst_valid,
    .rdata_valid,
    .mem_rvalid,
    .bank_start,
    .bank_write
);

//--- rtl/mem_subsys_top.sv
module mem_subsys_top #(
    parameter int NUM_BANKS  = mem_map_pkg::DEF_NUM_BANKS,
    parameter int BANK_WORDS = mem_map_pkg::DEF_BANK_WORDS
) (
    input  logic                           clk,
    input  logic                           rst_n,

    input  logic                           inst_start,
    output logic                           inst_ready,
    input  logic [mem_cmd_pkg::ADDR_W-1:0] i_addr,
    output logic                           inst_valid,
    output logic [mem_cmd_pkg::DATA_W-1:0] inst,

    input  mem_cmd_pkg::mem_cmd_e          d_cmd,
    output logic                           d_cmd_ready,
    input  logic [mem_cmd_pkg::ADDR_W-1:0] d_addr,
    input  logic [mem_cmd_pkg::DATA_W-1:0] wdata,
    input  logic [mem_cmd_pkg::DATA_W-1:0] wmask,
    output logic                           rdata_valid,
    output logic [mem_cmd_pkg::DATA_W-1:0] rdata
);
    import mem_cmd_pkg::*;

    localparam int IDX_W = (NUM_BANKS > 1) ? $clog2(NUM_BANKS) : 1;
    localparam int ROW_W = (BANK_WORDS > 1) ? $clog2(BANK_WORDS) : 1;

    logic [NUM_BANKS-1:0]             bank_start;
    logic [IDX_W-1:0]                 bank_index;
    logic                             bank_write;
    logic [ROW_W-1:0]                 bank_row;
    logic [DATA_W-1:0]                bank_wdata;
    logic [DATA_W-1:0]                bank_wmask;
    logic [NUM_BANKS-1:0]             bank_ready;
    logic [NUM_BANKS-1:0]             bank_rvalid;
    logic [NUM_BANKS-1:0][DATA_W-1:0] bank_rdata;
    logic                             sel_ready;
    logic                             mem_rvalid;
    logic [DATA_W-1:0]                mem_rdata;

    mem_port_arbiter #(
        .NUM_BANKS  (NUM_BANKS),
        .BANK_WORDS (BANK_WORDS)
    ) i_arbiter (
        .clk, .rst_n,
        .inst_start, .inst_ready, .i_addr, .inst_valid, .inst,
        .d_cmd, .d_cmd_ready, .d_addr, .wdata, .wmask, .rdata_valid, .rdata,
        .bank_start, .bank_index, .bank_write, .bank_row, .bank_wdata, .bank_wmask,
        .sel_ready, .mem_rvalid, .mem_rdata
    );

    // word-interleaved banks
    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
        mem_bank #(
            .BANK_WORDS (BANK_WORDS)
        ) i_bank (
            .clk, .rst_n,
            .start  (bank_start[b]),
            .write  (bank_write),
            .row    (bank_row),
            .wdata  (bank_wdata),
            .wmask  (bank_wmask),
            .ready  (bank_ready[b]),
            .rvalid (bank_rvalid[b]),
            .rdata  (bank_rdata[b])
        );
    end

    bank_return_merge #(
        .NUM_BANKS (NUM_BANKS)
    ) i_merge (
        .bank_ready, .bank_rvalid, .bank_rdata, .bank_index,
        .sel_ready, .mem_rvalid, .mem_rdata
    );

endmodule

//--- rtl/mem_port_arbiter.sv
module mem_port_arbiter #(
    parameter int   NUM_BANKS  = mem_map_pkg::DEF_NUM_BANKS,
    parameter int   BANK_WORDS = mem_map_pkg::DEF_BANK_WORDS,
    localparam int  IDX_W      = (NUM_BANKS > 1) ? $clog2(NUM_BANKS) : 1,
    localparam int  ROW_W      = (BANK_WORDS > 1) ? $clog2(BANK_WORDS) : 1
) (
    input  logic                             clk,
    input  logic                             rst_n,

    // fetch port
    input  logic                             inst_start,
    output logic                             inst_ready,
    input  logic [mem_cmd_pkg::ADDR_W-1:0]   i_addr,
    output logic                             inst_valid,
    output logic [mem_cmd_pkg::DATA_W-1:0]   inst,

    // data port
    input  mem_cmd_pkg::mem_cmd_e            d_cmd,
    output logic                             d_cmd_ready,
    input  logic [mem_cmd_pkg::ADDR_W-1:0]   d_addr,
    input  logic [mem_cmd_pkg::DATA_W-1:0]   wdata,
    input  logic [mem_cmd_pkg::DATA_W-1:0]   wmask,
    output logic                             rdata_valid,
    output logic [mem_cmd_pkg::DATA_W-1:0]   rdata,

    // shared bank command
    output logic [NUM_BANKS-1:0]             bank_start,
    output logic [IDX_W-1:0]                 bank_index,
    output logic                             bank_write,
    output logic [ROW_W-1:0]                 bank_row,
    output logic [mem_cmd_pkg::DATA_W-1:0]   bank_wdata,
    output logic [mem_cmd_pkg::DATA_W-1:0]   bank_wmask,

    // from the return merger
    input  logic                             sel_ready,
    input  logic                             mem_rvalid,
    input  logic [mem_cmd_pkg::DATA_W-1:0]   mem_rdata
);
    import mem_cmd_pkg::*;
    import mem_map_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE,
        S_WAIT_READY,
        S_WAIT_READ
    } state_e;

    state_e            state;
    logic              cmd_is_inst;
    mem_cmd_e          save_d_cmd;
    logic [ADDR_W-1:0] save_i_addr;
    logic [ADDR_W-1:0] save_d_addr;
    logic [DATA_W-1:0] save_wdata;
    logic [DATA_W-1:0] save_wmask;

    logic              iss_req;
    logic              iss_write;
    logic [ADDR_W-1:0] iss_addr;
    logic [DATA_W-1:0] iss_wdata;
    logic [DATA_W-1:0] iss_wmask;
    logic              issue;

    // pick the request to put on the banks this cycle
    always_comb begin
        iss_req   = 1'b0;
        iss_write = 1'b0;
        iss_addr  = save_d_addr;
        iss_wdata = save_wdata;
        iss_wmask = save_wmask;
        unique case (state)
            S_IDLE: begin
                // fetch goes first when both arrive together
                iss_req   = inst_start || (d_cmd != MEM_CMD_NOP);
                iss_write = !inst_start && (d_cmd == MEM_CMD_WRITE);
                iss_addr  = inst_start ? i_addr : d_addr;
                iss_wdata = wdata;
                iss_wmask = wmask;
            end
            S_WAIT_READY: begin
                iss_req   = 1'b1;
                iss_write = !cmd_is_inst && (save_d_cmd == MEM_CMD_WRITE);
                iss_addr  = cmd_is_inst ? save_i_addr : save_d_addr;
            end
            S_WAIT_READ: begin
                // held data command follows in the fetch response cycle
                iss_req   = mem_rvalid && cmd_is_inst && (save_d_cmd != MEM_CMD_NOP);
                iss_write = save_d_cmd == MEM_CMD_WRITE;
            end
            default: ;
        endcase
    end

    assign bank_index = IDX_W'(bank_sel(iss_addr, NUM_BANKS));
    assign bank_row   = ROW_W'(word_sel(iss_addr, NUM_BANKS, BANK_WORDS));
    assign bank_write = iss_write;
    assign bank_wdata = iss_wdata;
    assign bank_wmask = iss_wmask;
    assign issue      = iss_req && sel_ready;

    always_comb begin
        bank_start = '0;
        bank_start[bank_index] = issue;
    end

    assign inst_ready  = state == S_IDLE;
    assign d_cmd_ready = state == S_IDLE;

    // responses steered by the outstanding-fetch flag
    assign inst_valid  = (state == S_WAIT_READ) && mem_rvalid && cmd_is_inst;
    assign rdata_valid = (state == S_WAIT_READ) && mem_rvalid && !cmd_is_inst;
    assign inst        = mem_rdata;
    assign rdata       = mem_rdata;

    // request copies, captured on every idle cycle
    always_ff @(posedge clk) begin
        if (state == S_IDLE) begin
            save_i_addr <= i_addr;
            save_d_addr <= d_addr;
            save_wdata  <= wdata;
            save_wmask  <= wmask;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= S_IDLE;
            cmd_is_inst <= 1'b0;
            save_d_cmd  <= MEM_CMD_NOP;
        end else begin
            unique case (state)
                S_IDLE: begin
                    save_d_cmd  <= d_cmd;
                    cmd_is_inst <= inst_start;
                    if (iss_req) begin
                        if (!issue) begin
                            state <= S_WAIT_READY;
                        end else if (!iss_write) begin
                            state <= S_WAIT_READ;
                        end
                    end
                end
                S_WAIT_READY: begin
                    if (issue) begin
                        state <= iss_write ? S_IDLE : S_WAIT_READ;
                    end
                end
                S_WAIT_READ: begin
                    if (mem_rvalid) begin
                        if (iss_req) begin
                            // fetch done, data command now owns the port
                            cmd_is_inst <= 1'b0;
                            if (!issue) begin
                                state <= S_WAIT_READY;
                            end else begin
                                state <= iss_write ? S_IDLE : S_WAIT_READ;
                            end
                        end else begin
                            state <= S_IDLE;
                        end
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

endmodule

//--- rtl/bank_return_merge.sv
module bank_return_merge #(
    parameter int  NUM_BANKS = mem_map_pkg::DEF_NUM_BANKS,
    localparam int IDX_W     = (NUM_BANKS > 1) ? $clog2(NUM_BANKS) : 1
) (
    input  logic [NUM_BANKS-1:0]                          bank_ready,
    input  logic [NUM_BANKS-1:0]                          bank_rvalid,
    input  logic [NUM_BANKS-1:0][mem_cmd_pkg::DATA_W-1:0] bank_rdata,
    input  logic [IDX_W-1:0]                              bank_index,
    output logic                                          sel_ready,
    output logic                                          mem_rvalid,
    output logic [mem_cmd_pkg::DATA_W-1:0]                mem_rdata
);
    import mem_cmd_pkg::*;

    // ready of the bank the arbiter is addressing
    assign sel_ready = bank_ready[bank_index];

    // only one bank answers per cycle
    assign mem_rvalid = |bank_rvalid;

    // one-hot select, OR of the gated words
    always_comb begin
        mem_rdata = '0;
        for (int b = 0; b < NUM_BANKS; b++) begin
            mem_rdata |= bank_rdata[b] & {DATA_W{bank_rvalid[b]}};
        end
    end

endmodule

//--- rtl/mem_bank.sv
module mem_bank #(
    parameter int  BANK_WORDS = mem_map_pkg::DEF_BANK_WORDS,
    localparam int ROW_W      = (BANK_WORDS > 1) ? $clog2(BANK_WORDS) : 1
) (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           start,
    input  logic                           write,
    input  logic [ROW_W-1:0]               row,
    input  logic [mem_cmd_pkg::DATA_W-1:0] wdata,
    input  logic [mem_cmd_pkg::DATA_W-1:0] wmask,
    output logic                           ready,
    output logic                           rvalid,
    output logic [mem_cmd_pkg::DATA_W-1:0] rdata
);
    import mem_cmd_pkg::*;

    logic [DATA_W-1:0] mem [BANK_WORDS];
    logic              recover;
    logic              accept;

    assign accept = start && ready;

    // no access in the cycle after a write
    assign ready = !recover;

    always_ff @(posedge clk) begin
        if (accept) begin
            if (write) begin
                // bitwise merge under the mask
                mem[row] <= (mem[row] & ~wmask) | (wdata & wmask);
            end else begin
                rdata <= mem[row];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rvalid  <= 1'b0;
            recover <= 1'b0;
        end else begin
            rvalid  <= accept && !write;
            recover <= accept && write;
        end
    end

endmodule

//--- rtl/mem_map_pkg.sv
package mem_map_pkg;

    // default geometry, 4 x 64 words
    localparam int DEF_NUM_BANKS  = 4;
    localparam int DEF_BANK_WORDS = 64;

    // bank index from the low word-address bits
    function automatic int unsigned bank_sel(
        input logic [mem_cmd_pkg::ADDR_W-1:0] addr,
        input int unsigned                    num_banks
    );
        return (addr >> $clog2(mem_cmd_pkg::WORD_BYTES)) & (num_banks - 1);
    endfunction

    // row inside the bank, wraps modulo the bank depth
    function automatic int unsigned word_sel(
        input logic [mem_cmd_pkg::ADDR_W-1:0] addr,
        input int unsigned                    num_banks,
        input int unsigned                    bank_words
    );
        return ((addr >> $clog2(mem_cmd_pkg::WORD_BYTES)) >> $clog2(num_banks))
            & (bank_words - 1);
    endfunction

endpackage

//--- rtl/mem_cmd_pkg.sv
package mem_cmd_pkg;

    // byte address width seen by both request ports
    localparam int ADDR_W = 32;

    // data word and write mask width
    localparam int DATA_W = 32;

    // bytes per word, used for the word-address shift
    localparam int WORD_BYTES = DATA_W / 8;

    // data port command, same three-bit coding as the core side
    typedef enum logic [2:0] {
        MEM_CMD_NOP   = 3'd0,
        MEM_CMD_READ  = 3'd1,
        MEM_CMD_WRITE = 3'd2
    } mem_cmd_e;

endpackage
